// ==== Bender.yml ====
package:
  name: sctrl_wrapper

sources:
  - axi_pkg.sv
  - sctrl_pkg.sv
  - sctrl_axi_decode.sv
  - sensor_ctrl.sv
  - sctrl_resp.sv
  - sctrl_wrapper.sv
  - target: simulation
    files:
      - tb_sctrl_wrapper.sv

// ==== axi_pkg.sv ====
package axi_pkg;

    // Bus widths
    localparam int AXI_ID_BITS    = 4;
    localparam int AXI_ADDR_BITS  = 32;
    localparam int AXI_DATA_BITS  = 32;
    localparam int AXI_LEN_BITS   = 4;
    localparam int AXI_BURST_BITS = 2;

    // Response and burst codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [AXI_BURST_BITS-1:0] BURST_FIXED = 2'b00;

    typedef logic [AXI_ID_BITS-1:0]   axi_id_t;
    typedef logic [AXI_ADDR_BITS-1:0] axi_addr_t;
    typedef logic [AXI_DATA_BITS-1:0] axi_data_t;
    typedef logic [AXI_LEN_BITS-1:0]  axi_len_t;
    typedef logic [1:0]               axi_resp_t;

    // Shared by AW and AR
    typedef struct packed {
        axi_id_t                   id;
        axi_addr_t                 addr;
        axi_len_t                  len;
        logic [AXI_BURST_BITS-1:0] burst;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

endpackage

// ==== sctrl_axi_decode.sv ====
`timescale 1ns/100ps

module sctrl_axi_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  axi_pkg::axi_ax_t     aw_i,
    input  logic                 awvalid_i,
    output logic                 awready_o,
    input  axi_pkg::axi_w_t      w_i,
    input  logic                 wvalid_i,
    output logic                 wready_o,
    output logic                 bvalid_o,
    input  logic                 bready_i,
    input  axi_pkg::axi_ax_t     ar_i,
    input  logic                 arvalid_i,
    output logic                 arready_o,
    output logic                 rvalid_o,
    input  logic                 rready_i,
    output logic                 wr_en_o,
    output sctrl_pkg::region_t   wr_region_o,
    output logic                 wr_bit_o,
    output sctrl_pkg::word_addr_t cur_word_o,
    output sctrl_pkg::region_t   cur_region_o,
    output axi_pkg::axi_id_t     ax_id_o,
    output logic                 beat_last_o,
    output logic                 wr_err_o
);

    import axi_pkg::*;
    import sctrl_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        W_CH,
        B_CH,
        R_CH
    } state_t;

    state_t state, next;

    logic aw_hs, ar_hs, w_hs, r_hs, b_hs;
    logic wr_fin, rd_fin;
    logic ax_hs;
    axi_ax_t ax_sel;

    // Captured address phase
    axi_id_t                   ax_id_q;
    axi_len_t                  ax_len_q;
    logic [AXI_BURST_BITS-1:0] ax_burst_q;
    word_addr_t                cur_word;
    axi_len_t                  cnt;
    region_t                   region;
    logic                      wr_err;

    assign aw_hs  = awvalid_i & awready_o;
    assign ar_hs  = arvalid_i & arready_o;
    assign w_hs   = wvalid_i & wready_o;
    assign r_hs   = rvalid_o & rready_i;
    assign b_hs   = bvalid_o & bready_i;
    assign wr_fin = w_hs & w_i.last;
    assign rd_fin = r_hs & beat_last_o;
    assign ax_hs  = aw_hs | ar_hs;

    // AW wins when both are offered
    assign ax_sel = aw_hs ? aw_i : ar_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    next = wr_fin ? B_CH : W_CH;
                end else if (ar_hs) begin
                    next = R_CH;
                end
            end
            W_CH: begin
                if (wr_fin) begin
                    next = B_CH;
                end
            end
            B_CH: begin
                if (b_hs) begin
                    next = aw_hs ? W_CH : ar_hs ? R_CH : IDLE;
                end
            end
            R_CH: begin
                if (rd_fin) begin
                    next = aw_hs ? W_CH : ar_hs ? R_CH : IDLE;
                end
            end
            default: next = IDLE;
        endcase
    end

    // Ready and valid per state; new address only on the final response
    always_comb begin
        awready_o = 1'b0;
        arready_o = 1'b0;
        wready_o  = 1'b0;
        case (state)
            IDLE: begin
                awready_o = 1'b1;
                arready_o = ~awvalid_i;
            end
            W_CH: wready_o = 1'b1;
            B_CH: begin
                awready_o = b_hs;
                arready_o = b_hs & ~awvalid_i;
            end
            R_CH: begin
                awready_o = rd_fin;
                arready_o = rd_fin & ~awvalid_i;
            end
            default: ;
        endcase
    end

    assign bvalid_o = (state == B_CH);
    assign rvalid_o = (state == R_CH);

    always_ff @(posedge clk) begin
        if (ax_hs) begin
            ax_id_q    <= ax_sel.id;
            ax_len_q   <= ax_sel.len;
            ax_burst_q <= ax_sel.burst;
        end
    end

    // Word address steps per beat unless FIXED
    always_ff @(posedge clk) begin
        if (ax_hs) begin
            cur_word <= ax_sel.addr[WORD_LSB +: WORD_ADDR_BITS];
        end else if ((w_hs || r_hs) && ax_burst_q != BURST_FIXED) begin
            cur_word <= cur_word + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (ax_hs) begin
            cnt <= '0;
        end else if (wr_fin || rd_fin) begin
            cnt <= '0;
        end else if (w_hs || r_hs) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        if (cur_word < word_addr_t'(SBUF_DEPTH)) begin
            region = REGION_BUF;
        end else if (cur_word == REG_ENABLE) begin
            region = REGION_ENABLE;
        end else if (cur_word == REG_CLEAR) begin
            region = REGION_CLEAR;
        end else begin
            region = REGION_NONE;
        end
    end

    // Sticky over the burst; buffer is read only
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_err <= 1'b0;
        end else if (aw_hs) begin
            wr_err <= 1'b0;
        end else if (w_hs && (region == REGION_BUF || region == REGION_NONE)) begin
            wr_err <= 1'b1;
        end
    end

    assign wr_en_o      = w_hs;
    assign wr_region_o  = region;
    assign wr_bit_o     = w_i.data[0];
    assign cur_word_o   = cur_word;
    assign cur_region_o = region;
    assign ax_id_o      = ax_id_q;
    assign beat_last_o  = (cnt == ax_len_q);
    assign wr_err_o     = wr_err;

endmodule

// ==== sctrl_pkg.sv ====
package sctrl_pkg;

    // Sample buffer
    localparam int SBUF_DEPTH    = 64;
    localparam int SBUF_IDX_BITS = 6;

    // Word address taken from byte address bits 10:2
    localparam int WORD_ADDR_BITS = 9;
    localparam int WORD_LSB       = 2;

    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;

    // Register map, in words
    localparam word_addr_t REG_ENABLE = 9'h040;
    localparam word_addr_t REG_CLEAR  = 9'h080;

    typedef enum logic [1:0] {
        REGION_BUF,
        REGION_ENABLE,
        REGION_CLEAR,
        REGION_NONE
    } region_t;

    // One sensor word is one bus word
    typedef axi_pkg::axi_data_t sample_t;

endpackage

// ==== sctrl_resp.sv ====
`timescale 1ns/100ps

module sctrl_resp (
    input  sctrl_pkg::word_addr_t cur_word_i,
    input  sctrl_pkg::region_t    cur_region_i,
    input  axi_pkg::axi_id_t      ax_id_i,
    input  logic                  beat_last_i,
    input  logic                  wr_err_i,
    input  sctrl_pkg::sample_t    buf_word_i,
    input  logic                  enable_i,
    input  logic                  clear_i,
    output axi_pkg::axi_r_t       r_o,
    output axi_pkg::axi_b_t       b_o
);

    import axi_pkg::*;
    import sctrl_pkg::*;

    axi_data_t rdata;

    always_comb begin
        case (cur_region_i)
            REGION_BUF: begin
                rdata = buf_word_i;
            end
            REGION_ENABLE: begin
                rdata = axi_data_t'(enable_i);
            end
            REGION_CLEAR: begin
                rdata = axi_data_t'(clear_i);
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

    always_comb begin
        r_o.id   = ax_id_i;
        r_o.data = rdata;
        r_o.last = beat_last_i;
        if (cur_region_i == REGION_NONE) begin
            r_o.resp = RESP_SLVERR;
        end else begin
            r_o.resp = RESP_OKAY;
        end
    end

    // Write error accumulated over the whole burst
    always_comb begin
        b_o.id = ax_id_i;
        if (wr_err_i) begin
            b_o.resp = RESP_SLVERR;
        end else begin
            b_o.resp = RESP_OKAY;
        end
    end

endmodule

// ==== sctrl_wrapper.sv ====
`timescale 1ns/100ps

module sctrl_wrapper (
    input  logic               clk,
    input  logic               rst,
    input  axi_pkg::axi_ax_t   aw_i,
    input  logic               awvalid_i,
    output logic               awready_o,
    input  axi_pkg::axi_w_t    w_i,
    input  logic               wvalid_i,
    output logic               wready_o,
    output axi_pkg::axi_b_t    b_o,
    output logic               bvalid_o,
    input  logic               bready_i,
    input  axi_pkg::axi_ax_t   ar_i,
    input  logic               arvalid_i,
    output logic               arready_o,
    output axi_pkg::axi_r_t    r_o,
    output logic               rvalid_o,
    input  logic               rready_i,
    input  logic               sensor_ready_i,
    input  sctrl_pkg::sample_t sensor_out_i,
    output logic               sensor_en_o,
    output logic               sctrl_int_o
);

    import axi_pkg::*;
    import sctrl_pkg::*;

    // Decoder to sensor controller
    logic    wr_en;
    region_t wr_region;
    logic    wr_bit;

    // Decoder to response
    word_addr_t cur_word;
    region_t    cur_region;
    axi_id_t    ax_id;
    logic       beat_last;
    logic       wr_err;

    // Sensor controller readback
    sample_t buf_word;
    logic    enable;
    logic    clear;

    sctrl_axi_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .aw_i         (aw_i),
        .awvalid_i    (awvalid_i),
        .awready_o    (awready_o),
        .w_i          (w_i),
        .wvalid_i     (wvalid_i),
        .wready_o     (wready_o),
        .bvalid_o     (bvalid_o),
        .bready_i     (bready_i),
        .ar_i         (ar_i),
        .arvalid_i    (arvalid_i),
        .arready_o    (arready_o),
        .rvalid_o     (rvalid_o),
        .rready_i     (rready_i),
        .wr_en_o      (wr_en),
        .wr_region_o  (wr_region),
        .wr_bit_o     (wr_bit),
        .cur_word_o   (cur_word),
        .cur_region_o (cur_region),
        .ax_id_o      (ax_id),
        .beat_last_o  (beat_last),
        .wr_err_o     (wr_err)
    );

    sensor_ctrl u_sensor_ctrl (
        .clk            (clk),
        .rst            (rst),
        .wr_en_i        (wr_en),
        .wr_region_i    (wr_region),
        .wr_bit_i       (wr_bit),
        .rd_idx_i       (cur_word[SBUF_IDX_BITS-1:0]),
        .sensor_ready_i (sensor_ready_i),
        .sensor_out_i   (sensor_out_i),
        .sensor_en_o    (sensor_en_o),
        .sctrl_int_o    (sctrl_int_o),
        .enable_o       (enable),
        .clear_o        (clear),
        .buf_word_o     (buf_word)
    );

    sctrl_resp u_resp (
        .cur_word_i   (cur_word),
        .cur_region_i (cur_region),
        .ax_id_i      (ax_id),
        .beat_last_i  (beat_last),
        .wr_err_i     (wr_err),
        .buf_word_i   (buf_word),
        .enable_i     (enable),
        .clear_i      (clear),
        .r_o          (r_o),
        .b_o          (b_o)
    );

endmodule

// ==== sensor_ctrl.sv ====
`timescale 1ns/100ps

module sensor_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_en_i,
    input  sctrl_pkg::region_t                  wr_region_i,
    input  logic                                wr_bit_i,
    input  logic [sctrl_pkg::SBUF_IDX_BITS-1:0] rd_idx_i,
    input  logic                                sensor_ready_i,
    input  sctrl_pkg::sample_t                  sensor_out_i,
    output logic                                sensor_en_o,
    output logic                                sctrl_int_o,
    output logic                                enable_o,
    output logic                                clear_o,
    output sctrl_pkg::sample_t                  buf_word_o
);

    import sctrl_pkg::*;

    logic enable_q;
    logic clear_q;

    sample_t                  sbuf [SBUF_DEPTH];
    logic [SBUF_IDX_BITS-1:0] wr_ptr;
    logic                     full;
    logic                     capture;

    // Control registers take wdata bit 0
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            enable_q <= 1'b0;
            clear_q  <= 1'b0;
        end else if (wr_en_i) begin
            if (wr_region_i == REGION_ENABLE) begin
                enable_q <= wr_bit_i;
            end
            if (wr_region_i == REGION_CLEAR) begin
                clear_q <= wr_bit_i;
            end
        end
    end

    assign sensor_en_o = enable_q & ~full & ~clear_q;
    assign capture     = sensor_ready_i & sensor_en_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else if (clear_q) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else if (capture) begin
            wr_ptr <= wr_ptr + 1'b1;
            // Last slot taken
            if (wr_ptr == SBUF_IDX_BITS'(SBUF_DEPTH - 1)) begin
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            sbuf[wr_ptr] <= sensor_out_i;
        end
    end

    assign buf_word_o  = sbuf[rd_idx_i];
    assign sctrl_int_o = full;
    assign enable_o    = enable_q;
    assign clear_o     = clear_q;

endmodule

// ==== sources.f ====
axi_pkg.sv
sctrl_pkg.sv
sctrl_axi_decode.sv
sensor_ctrl.sv
sctrl_resp.sv
sctrl_wrapper.sv
tb_sctrl_wrapper.sv

// ==== tb_sctrl_wrapper.sv ====
`timescale 1ns/100ps

module tb_sctrl_wrapper;

    import axi_pkg::*;
    import sctrl_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam logic [1:0] BURST_INCR = 2'b01;
    // Two capture rounds at most 4 cycles per sample, fifteen bursts of up to 40 cycles
    localparam int RUN_CYCLES = 2 * 64 * 4 + 15 * 40;
    localparam int TIME_LIMIT = 2 * RUN_CYCLES * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    axi_ax_t aw_i, ar_i;
    axi_w_t  w_i;
    axi_b_t  b_o;
    axi_r_t  r_o;
    logic awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
    logic arvalid_i, arready_o, rvalid_o, rready_i;
    logic sensor_ready_i, sensor_en_o, sctrl_int_o;
    sample_t sensor_out_i;

    int seed = 72380;
    int errors = 0;
    int nsamp = 0;
    logic [31:0] srnd;
    sample_t   exp_buf [SBUF_DEPTH];
    axi_data_t rd_data [16];
    axi_resp_t rd_resp [16];

    sctrl_wrapper uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Sensor model, records what the controller will store
    always @(negedge clk) begin
        srnd = $random(seed);
        sensor_ready_i = sensor_en_o && (srnd[1:0] != 2'b00);
        sensor_out_i = $random(seed);
        if (sensor_ready_i && nsamp < SBUF_DEPTH) begin
            exp_buf[nsamp] = sensor_out_i;
            nsamp = nsamp + 1;
        end
    end

    r_stable: assert property (@(posedge clk) disable iff (!rst)
        rvalid_o && !rready_i |=> rvalid_o && $stable(r_o))
        else begin
            errors++;
            $display("read data changed or dropped before rready");
        end

    b_stable: assert property (@(posedge clk) disable iff (!rst)
        bvalid_o && !bready_i |=> bvalid_o && $stable(b_o))
        else begin
            errors++;
            $display("write response changed or dropped before bready");
        end

    int_stops_capture: assert property (@(posedge clk) disable iff (!rst)
        sctrl_int_o |-> !sensor_en_o)
        else begin
            errors++;
            $display("sensor still enabled while the interrupt is raised");
        end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic write_burst(input axi_id_t id, input word_addr_t word, input axi_len_t len,
                               input axi_data_t data, input axi_resp_t exp_resp);
        int beat;
        logic [31:0] rnd;
        @(negedge clk);
        aw_i = '{id: id, addr: axi_addr_t'({word, 2'b00}), len: len, burst: BURST_INCR};
        awvalid_i = 1'b1;
        #1;
        while (!awready_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid_i = 1'b0;
        for (beat = 0; beat <= len; beat++) begin
            w_i = '{data: data, last: (beat == len)};
            wvalid_i = 1'b1;
            #1;
            while (!wready_o) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        wvalid_i = 1'b0;
        // Hold off bready for a few cycles
        rnd = $random(seed);
        repeat (1 + rnd[1:0]) @(negedge clk);
        bready_i = 1'b1;
        #1;
        while (!bvalid_o) begin
            @(negedge clk);
            #1;
        end
        check_value("bresp", exp_resp, b_o.resp);
        check_value("bid", id, b_o.id);
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    task automatic read_burst(input axi_id_t id, input word_addr_t word, input axi_len_t len,
                              input logic [1:0] burst, input logic stall);
        int beat;
        logic [31:0] rnd;
        @(negedge clk);
        ar_i = '{id: id, addr: axi_addr_t'({word, 2'b00}), len: len, burst: burst};
        arvalid_i = 1'b1;
        #1;
        while (!arready_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid_i = 1'b0;
        beat = 0;
        while (beat <= len) begin
            rnd = $random(seed);
            rready_i = stall ? rnd[0] : 1'b1;
            #1;
            if (rvalid_o) begin
                check_value("rlast", (beat == len), r_o.last);
            end
            if (rvalid_o && rready_i) begin
                check_value("rid", id, r_o.id);
                rd_data[beat] = r_o.data;
                rd_resp[beat] = r_o.resp;
                beat++;
            end
            @(negedge clk);
        end
        rready_i = 1'b0;
    endtask

    initial begin
        rst = 1'b0;
        aw_i = '0;
        ar_i = '0;
        w_i = '0;
        awvalid_i = 1'b0;
        wvalid_i = 1'b0;
        bready_i = 1'b0;
        arvalid_i = 1'b0;
        rready_i = 1'b0;
        sensor_ready_i = 1'b0;
        sensor_out_i = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        #1;
        check_value("awready_o", 1, awready_o);
        check_value("wready_o", 0, wready_o);
        check_value("bvalid_o", 0, bvalid_o);
        check_value("rvalid_o", 0, rvalid_o);
        check_value("sensor_en_o", 0, sensor_en_o);
        check_value("sctrl_int_o", 0, sctrl_int_o);

        write_burst(4'h3, REG_ENABLE, 4'd0, 32'h1, RESP_OKAY);
        check_value("sensor_en_o", 1, sensor_en_o);
        wait (sctrl_int_o);
        @(negedge clk);
        check_value("sample count", SBUF_DEPTH, nsamp);
        check_value("sensor_en_o", 0, sensor_en_o);

        // Whole buffer in four bursts, with rready stalls
        for (int k = 0; k < 4; k++) begin
            read_burst(axi_id_t'(k + 4), word_addr_t'(k * 16), 4'd15, BURST_INCR, 1'b1);
            for (int i = 0; i < 16; i++) begin
                check_value("rdata", exp_buf[k * 16 + i], rd_data[i]);
                check_value("rresp", RESP_OKAY, rd_resp[i]);
            end
        end

        read_burst(4'h1, REG_ENABLE, 4'd0, BURST_INCR, 1'b0);
        check_value("rdata enable", 1, rd_data[0]);
        read_burst(4'h2, REG_CLEAR, 4'd0, BURST_INCR, 1'b0);
        check_value("rdata clear", 0, rd_data[0]);
        read_burst(4'h9, 9'h005, 4'd3, BURST_FIXED, 1'b1);
        for (int i = 0; i < 4; i++) begin
            check_value("rdata fixed", exp_buf[5], rd_data[i]);
        end

        write_burst(4'h6, 9'h010, 4'd1, 32'h0, RESP_SLVERR);
        write_burst(4'h7, 9'h0FF, 4'd1, 32'h0, RESP_SLVERR);
        read_burst(4'hA, 9'h100, 4'd0, BURST_INCR, 1'b0);
        check_value("rresp unmapped", RESP_SLVERR, rd_resp[0]);
        check_value("rdata unmapped", 0, rd_data[0]);

        write_burst(4'hB, REG_CLEAR, 4'd0, 32'h1, RESP_OKAY);
        check_value("sctrl_int_o", 0, sctrl_int_o);
        nsamp = 0;
        read_burst(4'hC, REG_CLEAR, 4'd0, BURST_INCR, 1'b0);
        check_value("rdata clear", 1, rd_data[0]);
        write_burst(4'hD, REG_CLEAR, 4'd0, 32'h0, RESP_OKAY);
        wait (nsamp >= 8);
        read_burst(4'hE, 9'h000, 4'd7, BURST_INCR, 1'b1);
        for (int i = 0; i < 8; i++) begin
            check_value("rdata after clear", exp_buf[i], rd_data[i]);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIME_LIMIT);
        $display("timeout: the run did not complete in %0d ns, errors: %0d", TIME_LIMIT, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule
